//--- lsu_pkg.sv
package lsu_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } mem_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_e;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    localparam int QUEUE_DEPTH = 4; // the issue stage also starts with this many credits.
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    localparam addr_t SRAM_BASE  = 32'hA000_0000;
    localparam int    SRAM_WORDS = 256;
    localparam int    SRAM_IDX_W = $clog2(SRAM_WORDS);
    localparam addr_t SRAM_END   = SRAM_BASE + addr_t'(SRAM_WORDS * 4); // first byte past the window.

endpackage

//--- lsu_issue.sv
module lsu_issue (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    output logic               req_ready,
    input  lsu_pkg::mem_op_e   req_op,
    input  lsu_pkg::mem_size_e req_size,
    input  logic               req_sext,
    input  lsu_pkg::addr_t     req_addr,
    input  lsu_pkg::data_t     req_wdata,
    output logic               push,
    output lsu_pkg::mem_op_e   q_op,
    output lsu_pkg::mem_size_e q_size,
    output logic               q_sext,
    output lsu_pkg::addr_t     q_addr,
    output lsu_pkg::data_t     q_wdata,
    output lsu_pkg::strb_t     q_strb,
    output logic               q_misalign,
    input  logic               credit_return
);
    import lsu_pkg::*;

    logic                   accept;
    logic [1:0]             offset;
    logic [QUEUE_CNT_W-1:0] credits;
    logic [QUEUE_CNT_W-1:0] credits_next;
    strb_t                  strb;
    logic                   misalign;

    assign accept       = req_valid && req_ready;
    assign offset       = req_addr[1:0];
    assign credits_next = credits - QUEUE_CNT_W'(accept) + QUEUE_CNT_W'(credit_return);

    always_comb begin
        case (req_size)
            SZ_BYTE: begin
                strb     = 4'b0001 << offset;
                misalign = 1'b0;
            end
            SZ_HALF: begin
                strb     = 4'b0011 << offset;
                misalign = offset[0];
            end
            default: begin
                strb     = 4'b1111 << offset;
                misalign = |offset; // words must sit on a 4-byte boundary.
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits   <= QUEUE_CNT_W'(QUEUE_DEPTH);
            req_ready <= 1'b0;
            push      <= 1'b0;
        end else begin
            credits   <= credits_next;
            req_ready <= credits_next != '0; // tracks the credit count one edge ahead.
            push      <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            q_op       <= req_op;
            q_size     <= req_size;
            q_sext     <= req_sext;
            q_addr     <= req_addr;
            q_wdata    <= req_wdata << {offset, 3'b000}; // move store data into its lane.
            q_strb     <= strb;
            q_misalign <= misalign;
        end
    end

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= QUEUE_CNT_W'(QUEUE_DEPTH));

endmodule

//--- lsu_req_fifo.sv
module lsu_req_fifo (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  lsu_pkg::mem_op_e   q_op,
    input  lsu_pkg::mem_size_e q_size,
    input  logic               q_sext,
    input  lsu_pkg::addr_t     q_addr,
    input  lsu_pkg::data_t     q_wdata,
    input  lsu_pkg::strb_t     q_strb,
    input  logic               q_misalign,
    input  logic               pop,
    output logic               not_empty,
    output lsu_pkg::mem_op_e   h_op,
    output lsu_pkg::mem_size_e h_size,
    output logic               h_sext,
    output lsu_pkg::addr_t     h_addr,
    output lsu_pkg::data_t     h_wdata,
    output lsu_pkg::strb_t     h_strb,
    output logic               h_misalign,
    output logic               credit_return
);
    import lsu_pkg::*;

    mem_op_e                op_mem       [QUEUE_DEPTH];
    mem_size_e              size_mem     [QUEUE_DEPTH];
    logic                   sext_mem     [QUEUE_DEPTH];
    addr_t                  addr_mem     [QUEUE_DEPTH];
    data_t                  wdata_mem    [QUEUE_DEPTH];
    strb_t                  strb_mem     [QUEUE_DEPTH];
    logic                   misalign_mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;

    function automatic logic [QUEUE_PTR_W-1:0] ptr_inc(input logic [QUEUE_PTR_W-1:0] ptr);
        return (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            count         <= count + QUEUE_CNT_W'(push) - QUEUE_CNT_W'(pop);
            credit_return <= pop; // each freed slot goes back to the issue stage.
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]       <= q_op;
            size_mem[wr_ptr]     <= q_size;
            sext_mem[wr_ptr]     <= q_sext;
            addr_mem[wr_ptr]     <= q_addr;
            wdata_mem[wr_ptr]    <= q_wdata;
            strb_mem[wr_ptr]     <= q_strb;
            misalign_mem[wr_ptr] <= q_misalign;
        end
    end

    assign not_empty  = count != '0;
    assign h_op       = op_mem[rd_ptr];
    assign h_size     = size_mem[rd_ptr];
    assign h_sext     = sext_mem[rd_ptr];
    assign h_addr     = addr_mem[rd_ptr];
    assign h_wdata    = wdata_mem[rd_ptr];
    assign h_strb     = strb_mem[rd_ptr];
    assign h_misalign = misalign_mem[rd_ptr];

    no_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> count < QUEUE_CNT_W'(QUEUE_DEPTH));
    no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> not_empty);

endmodule

//--- lsu_axi_master.sv
module lsu_axi_master (
    input  logic               clk,
    input  logic               rst,
    input  logic               not_empty,
    input  lsu_pkg::mem_op_e   h_op,
    input  lsu_pkg::mem_size_e h_size,
    input  logic               h_sext,
    input  lsu_pkg::addr_t     h_addr,
    input  lsu_pkg::data_t     h_wdata,
    input  lsu_pkg::strb_t     h_strb,
    input  logic               h_misalign,
    output logic               pop,
    output logic               awvalid,
    input  logic               awready,
    output lsu_pkg::addr_t     awaddr,
    output logic [2:0]         awsize,
    output logic               wvalid,
    input  logic               wready,
    output lsu_pkg::data_t     wdata,
    output lsu_pkg::strb_t     wstrb,
    input  logic               bvalid,
    output logic               bready,
    input  lsu_pkg::resp_t     bresp,
    output logic               arvalid,
    input  logic               arready,
    output lsu_pkg::addr_t     araddr,
    output logic [2:0]         arsize,
    input  logic               rvalid,
    output logic               rready,
    input  lsu_pkg::data_t     rdata,
    input  lsu_pkg::resp_t     rresp,
    output logic               rsp_valid,
    output lsu_pkg::mem_op_e   rsp_op,
    output lsu_pkg::data_t     rsp_data,
    output logic               rsp_fault
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        READ_ADDR,
        READ_DATA,
        WRITE_REQ,
        WRITE_RESP,
        RESPOND_FAULT
    } state_e;

    state_e     state;
    mem_size_e  cur_size;
    logic       cur_sext;
    logic [1:0] cur_off;
    logic       aw_pending;
    logic       w_pending;
    data_t      shifted;
    data_t      load_data;

    assign pop        = (state == IDLE) && not_empty;
    assign aw_pending = awvalid && !awready;
    assign w_pending  = wvalid && !wready;
    assign shifted    = rdata >> {cur_off, 3'b000};

    always_comb begin
        case (cur_size)
            SZ_BYTE: load_data = cur_sext ? {{24{shifted[7]}}, shifted[7:0]}
                                          : {24'b0, shifted[7:0]};
            SZ_HALF: load_data = cur_sext ? {{16{shifted[15]}}, shifted[15:0]}
                                          : {16'b0, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            bready    <= 1'b0;
            arvalid   <= 1'b0;
            rready    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (pop) begin
                        if (h_misalign) begin
                            rsp_valid <= 1'b1; // never reaches the bus.
                            state     <= RESPOND_FAULT;
                        end else if (h_op == OP_LOAD) begin
                            arvalid <= 1'b1;
                            state   <= READ_ADDR;
                        end else begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= WRITE_REQ;
                        end
                    end
                end
                READ_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= READ_DATA;
                    end
                end
                READ_DATA: begin
                    if (rvalid) begin
                        rready    <= 1'b0;
                        rsp_valid <= 1'b1;
                        state     <= IDLE;
                    end
                end
                WRITE_REQ: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (!aw_pending && !w_pending) begin
                        bready <= 1'b1; // wait for B once both channels are done.
                        state  <= WRITE_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (bvalid) begin
                        bready    <= 1'b0;
                        rsp_valid <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_size  <= h_size;
            cur_sext  <= h_sext;
            cur_off   <= h_addr[1:0];
            araddr    <= h_addr;
            arsize    <= {1'b0, h_size};
            awaddr    <= h_addr;
            awsize    <= {1'b0, h_size};
            wdata     <= h_wdata;
            wstrb     <= h_strb;
            rsp_op    <= h_op;
            rsp_data  <= '0;
            rsp_fault <= h_misalign;
        end
        if (state == READ_DATA && rvalid) begin
            rsp_data  <= (rresp == RESP_OKAY) ? load_data : '0;
            rsp_fault <= rresp != RESP_OKAY;
        end
        if (state == WRITE_RESP && bvalid) begin
            rsp_fault <= bresp != RESP_OKAY;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr));

endmodule

//--- lsu_sram.sv
module lsu_sram (
    input  logic           clk,
    input  logic           rst,
    input  logic           awvalid,
    output logic           awready,
    input  lsu_pkg::addr_t awaddr,
    input  logic [2:0]     awsize,
    input  logic           wvalid,
    output logic           wready,
    input  lsu_pkg::data_t wdata,
    input  lsu_pkg::strb_t wstrb,
    output logic           bvalid,
    input  logic           bready,
    output lsu_pkg::resp_t bresp,
    input  logic           arvalid,
    output logic           arready,
    input  lsu_pkg::addr_t araddr,
    input  logic [2:0]     arsize,
    output logic           rvalid,
    input  logic           rready,
    output lsu_pkg::data_t rdata,
    output lsu_pkg::resp_t rresp
);
    import lsu_pkg::*;

    data_t                 mem [SRAM_WORDS];
    logic                  aw_hs;
    logic                  ar_hs;
    logic                  wr_ok;
    logic                  rd_ok;
    logic [SRAM_IDX_W-1:0] wr_idx;
    logic [SRAM_IDX_W-1:0] rd_idx;

    function automatic logic in_window(input addr_t a);
        return (a >= SRAM_BASE) && (a < SRAM_END);
    endfunction

    initial begin
        for (int i = 0; i < SRAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign awready = awvalid && wvalid && !bvalid; // AW and W are taken together.
    assign wready  = awready;
    assign aw_hs   = awvalid && awready;
    assign ar_hs   = arvalid && arready;
    assign wr_ok   = in_window(awaddr) && (awsize <= 3'd2);
    assign rd_ok   = in_window(araddr) && (arsize <= 3'd2);
    assign wr_idx  = awaddr[SRAM_IDX_W+1:2]; // base is aligned to the window size.
    assign rd_idx  = araddr[SRAM_IDX_W+1:2];

    always @(posedge clk) begin
        if (aw_hs && wr_ok) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        if (ar_hs) begin
            rdata <= rd_ok ? mem[rd_idx] : '0;
            rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            arready <= 1'b0;
        end else begin
            if (aw_hs) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;
            if (ar_hs) begin
                rvalid  <= 1'b1;
                arready <= 1'b0;
            end else if (rvalid && rready) begin
                rvalid  <= 1'b0;
                arready <= 1'b1;
            end else begin
                arready <= !rvalid;
            end
        end
    end

endmodule

//--- lsu_top.sv
module lsu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_valid,
    output logic               req_ready,
    input  lsu_pkg::mem_op_e   req_op,
    input  lsu_pkg::mem_size_e req_size,
    input  logic               req_sext,
    input  lsu_pkg::addr_t     req_addr,
    input  lsu_pkg::data_t     req_wdata,
    output logic               rsp_valid,
    output lsu_pkg::mem_op_e   rsp_op,
    output lsu_pkg::data_t     rsp_data,
    output logic               rsp_fault
);
    import lsu_pkg::*;

    logic      push, credit_return, not_empty, pop;
    mem_op_e   q_op, h_op;
    mem_size_e q_size, h_size;
    logic      q_sext, h_sext;
    addr_t     q_addr, h_addr;
    data_t     q_wdata, h_wdata;
    strb_t     q_strb, h_strb;
    logic      q_misalign, h_misalign;

    logic       awvalid, awready, wvalid, wready, bvalid, bready;
    logic       arvalid, arready, rvalid, rready;
    addr_t      awaddr, araddr;
    logic [2:0] awsize, arsize;
    data_t      wdata, rdata;
    strb_t      wstrb;
    resp_t      bresp, rresp;

    lsu_issue u_issue (
        .clk, .rst, .req_valid, .req_ready, .req_op, .req_size, .req_sext,
        .req_addr, .req_wdata, .push, .q_op, .q_size, .q_sext, .q_addr,
        .q_wdata, .q_strb, .q_misalign, .credit_return
    );

    lsu_req_fifo u_fifo (
        .clk, .rst, .push, .q_op, .q_size, .q_sext, .q_addr, .q_wdata, .q_strb,
        .q_misalign, .pop, .not_empty, .h_op, .h_size, .h_sext, .h_addr,
        .h_wdata, .h_strb, .h_misalign, .credit_return
    );

    lsu_axi_master u_master (
        .clk, .rst, .not_empty, .h_op, .h_size, .h_sext, .h_addr, .h_wdata,
        .h_strb, .h_misalign, .pop,
        .awvalid, .awready, .awaddr, .awsize, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .arsize,
        .rvalid, .rready, .rdata, .rresp,
        .rsp_valid, .rsp_op, .rsp_data, .rsp_fault
    );

    lsu_sram u_sram (
        .clk, .rst,
        .awvalid, .awready, .awaddr, .awsize, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .arsize,
        .rvalid, .rready, .rdata, .rresp
    );

endmodule

//--- tb_lsu_top.sv
module tb_lsu_top;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    typedef struct packed {
        mem_op_e   op;
        mem_size_e size;
        logic      sext;
        addr_t     addr;
        data_t     wdata;
        logic      fault;
        logic      burst; // offered back to back with the previous entry.
    } entry_t;

    typedef struct packed {
        mem_op_e op;
        data_t   data;
        logic    fault;
    } expect_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      req_valid;
    logic      req_ready;
    mem_op_e   req_op;
    mem_size_e req_size;
    logic      req_sext;
    addr_t     req_addr;
    data_t     req_wdata;
    logic      rsp_valid;
    mem_op_e   rsp_op;
    data_t     rsp_data;
    logic      rsp_fault;

    entry_t      table_q[$];
    expect_t     exp_q[$];
    logic [7:0]  ref_mem [SRAM_WORDS * 4];
    logic [31:0] lfsr = 32'ha358_9370;
    logic        table_built = 1'b0;
    logic        saw_stall = 1'b0;
    int          rsp_count = 0;

    lsu_top UUT (
        .clk, .rst, .req_valid, .req_ready, .req_op, .req_size, .req_sext,
        .req_addr, .req_wdata, .rsp_valid, .rsp_op, .rsp_data, .rsp_fault
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    function automatic int size_bytes(input mem_size_e sz);
        case (sz)
            SZ_BYTE: return 1;
            SZ_HALF: return 2;
            default: return 4;
        endcase
    endfunction

    // little-endian gather from the byte model, then widen by sign or zero.
    function automatic data_t model_load(input addr_t a, input mem_size_e sz, input logic sext);
        logic [SRAM_IDX_W+1:0] idx;
        int                    n;
        data_t                 v;
        idx = (SRAM_IDX_W + 2)'(a - SRAM_BASE);
        n = size_bytes(sz);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ref_mem[idx + (SRAM_IDX_W + 2)'(i)];
        end
        if (sext && v[8*n-1]) begin
            for (int i = n; i < 4; i++) begin
                v[8*i +: 8] = 8'hFF;
            end
        end
        return v;
    endfunction

    task automatic model_store(input addr_t a, input mem_size_e sz, input data_t d);
        logic [SRAM_IDX_W+1:0] idx;
        idx = (SRAM_IDX_W + 2)'(a - SRAM_BASE);
        for (int i = 0; i < size_bytes(sz); i++) begin
            ref_mem[idx + (SRAM_IDX_W + 2)'(i)] = d[8*i +: 8];
        end
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] time %0t %s expected %h got %h", $time, name, expected, actual);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic add_entry(input mem_op_e op, input mem_size_e sz, input logic sext,
                             input addr_t a, input data_t d, input logic fault,
                             input logic burst);
        entry_t e;
        e = '{op: op, size: sz, sext: sext, addr: a, wdata: d, fault: fault, burst: burst};
        table_q.push_back(e);
    endtask

    task automatic build_table();
        add_entry(OP_STORE, SZ_WORD, 1'b0, SRAM_BASE + 32'h10, 32'hDEAD_BEEF, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_WORD, 1'b0, SRAM_BASE + 32'h10, 32'h0, 1'b0, 1'b0);
        add_entry(OP_STORE, SZ_WORD, 1'b0, SRAM_BASE + 32'h20, 32'h1122_3344, 1'b0, 1'b0);
        add_entry(OP_STORE, SZ_BYTE, 1'b0, SRAM_BASE + 32'h21, 32'h1234_56A5, 1'b0, 1'b0);
        add_entry(OP_STORE, SZ_HALF, 1'b0, SRAM_BASE + 32'h22, 32'hCAFE_80F0, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_WORD, 1'b0, SRAM_BASE + 32'h20, 32'h0, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_HALF, 1'b1, SRAM_BASE + 32'h20, 32'h0, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_HALF, 1'b0, SRAM_BASE + 32'h20, 32'h0, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_HALF, 1'b1, SRAM_BASE + 32'h22, 32'h0, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_HALF, 1'b0, SRAM_BASE + 32'h22, 32'h0, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_BYTE, 1'b1, SRAM_BASE + 32'h20, 32'h0, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_BYTE, 1'b1, SRAM_BASE + 32'h21, 32'h0, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_BYTE, 1'b0, SRAM_BASE + 32'h21, 32'h0, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_BYTE, 1'b1, SRAM_BASE + 32'h22, 32'h0, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_BYTE, 1'b1, SRAM_BASE + 32'h23, 32'h0, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_BYTE, 1'b0, SRAM_BASE + 32'h23, 32'h0, 1'b0, 1'b0);
        add_entry(OP_STORE, SZ_WORD, 1'b0, 32'h9000_0000, 32'h5555_5555, 1'b1, 1'b0);
        add_entry(OP_LOAD,  SZ_WORD, 1'b0, 32'h9000_0000, 32'h0, 1'b1, 1'b0);
        add_entry(OP_STORE, SZ_WORD, 1'b0, SRAM_END, 32'h7777_7777, 1'b1, 1'b0);
        add_entry(OP_LOAD,  SZ_WORD, 1'b0, SRAM_END, 32'h0, 1'b1, 1'b0);
        add_entry(OP_LOAD,  SZ_WORD, 1'b0, SRAM_BASE, 32'h0, 1'b0, 1'b0); // would alias word 0.
        add_entry(OP_STORE, SZ_HALF, 1'b0, SRAM_BASE + 32'h31, 32'h0000_ABCD, 1'b1, 1'b0);
        add_entry(OP_STORE, SZ_WORD, 1'b0, SRAM_BASE + 32'h32, 32'hFFFF_FFFF, 1'b1, 1'b0);
        add_entry(OP_LOAD,  SZ_WORD, 1'b0, SRAM_BASE + 32'h12, 32'h0, 1'b1, 1'b0);
        add_entry(OP_LOAD,  SZ_HALF, 1'b1, SRAM_BASE + 32'h13, 32'h0, 1'b1, 1'b0);
        add_entry(OP_LOAD,  SZ_WORD, 1'b0, SRAM_BASE + 32'h30, 32'h0, 1'b0, 1'b0);
        add_entry(OP_LOAD,  SZ_WORD, 1'b0, SRAM_BASE + 32'h10, 32'h0, 1'b0, 1'b0);
        add_entry(OP_STORE, SZ_WORD, 1'b0, SRAM_BASE + 32'h40, 32'h0102_0304, 1'b0, 1'b1);
        add_entry(OP_STORE, SZ_WORD, 1'b0, SRAM_BASE + 32'h44, 32'hA1B2_C3D4, 1'b0, 1'b1);
        add_entry(OP_LOAD,  SZ_WORD, 1'b0, SRAM_BASE + 32'h40, 32'h0, 1'b0, 1'b1);
        add_entry(OP_LOAD,  SZ_BYTE, 1'b1, SRAM_BASE + 32'h47, 32'h0, 1'b0, 1'b1);
        add_entry(OP_STORE, SZ_HALF, 1'b0, SRAM_BASE + 32'h46, 32'h0000_7777, 1'b0, 1'b1);
        add_entry(OP_LOAD,  SZ_WORD, 1'b0, SRAM_BASE + 32'h44, 32'h0, 1'b0, 1'b1);
        add_entry(OP_LOAD,  SZ_WORD, 1'b0, SRAM_BASE + 32'h41, 32'h0, 1'b1, 1'b1);
        add_entry(OP_STORE, SZ_BYTE, 1'b0, SRAM_BASE + 32'h40, 32'h0000_00EE, 1'b0, 1'b1);
        add_entry(OP_LOAD,  SZ_WORD, 1'b0, SRAM_BASE + 32'h40, 32'h0, 1'b0, 1'b1);
        add_entry(OP_LOAD,  SZ_HALF, 1'b1, SRAM_BASE + 32'h42, 32'h0, 1'b0, 1'b1);
        add_entry(OP_LOAD,  SZ_BYTE, 1'b0, SRAM_BASE + 32'h40, 32'h0, 1'b0, 1'b1);
    endtask

    // called 1 ns after an edge and returns 1 ns after the accepting edge.
    task automatic send_request(input entry_t e);
        expect_t x;
        req_valid = 1'b1;
        req_op    = e.op;
        req_size  = e.size;
        req_sext  = e.sext;
        req_addr  = e.addr;
        req_wdata = e.wdata;
        while (!req_ready) begin
            if (e.burst) saw_stall = 1'b1;
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        x = '{op: e.op, data: '0, fault: e.fault};
        if (e.op == OP_LOAD && !e.fault) x.data = model_load(e.addr, e.size, e.sext);
        if (e.op == OP_STORE && !e.fault) model_store(e.addr, e.size, e.wdata);
        exp_q.push_back(x);
    endtask

    always @(negedge clk) begin : response_monitor
        expect_t e;
        if (!rst && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("rsp_valid pulsed at time %0t with no request outstanding", $time);
                $display("Checks failed");
                $fatal(1);
            end else begin
                e = exp_q.pop_front();
                check_equal("rsp_op", 32'(e.op), 32'(rsp_op));
                check_equal("rsp_fault", 32'(e.fault), 32'(rsp_fault));
                if (e.op == OP_LOAD) check_equal("rsp_data", e.data, rsp_data);
                rsp_count++;
            end
        end
    end

    initial begin : watchdog
        wait (table_built);
        repeat (table_q.size() * 40 + 10) @(posedge clk);
        $display("timeout: responses never arrived for all requests");
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        logic b0;
        logic b1;
        int   gap;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_op    = OP_LOAD;
        req_size  = SZ_WORD;
        req_sext  = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        for (int i = 0; i < SRAM_WORDS * 4; i++) begin
            ref_mem[i] = 8'h00;
        end
        build_table();
        table_built = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (5) @(posedge clk); // the monitor flags any stray response in this idle window.
        #1;
        foreach (table_q[i]) begin
            if (!table_q[i].burst) begin
                take_bit(b0);
                take_bit(b1);
                gap = int'({b1, b0});
                req_valid = 1'b0;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
            send_request(table_q[i]);
        end
        req_valid = 1'b0;
        wait (rsp_count == table_q.size());
        repeat (5) @(posedge clk);
        if (saw_stall) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("req_ready never dropped during the back-to-back run");
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

//--- all.f
lsu_pkg.sv
lsu_issue.sv
lsu_req_fifo.sv
lsu_axi_master.sv
lsu_sram.sv
lsu_top.sv
tb_lsu_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
